// ==== logic/addr_pkg.sv ====
// Address widths, IE location and the byte/word address view shared by the address logic

package addr_pkg;

	localparam int addr_w = 16; // Core address bus
	localparam int byte_w = 8;

	// IE register sits at the very top of the map
	localparam logic [addr_w-1:0] ie_addr = 16'hFFFF;

	// Byte view of an address word, high byte first
	typedef struct packed {
		logic [byte_w-1:0] hi;
		logic [byte_w-1:0] lo;
	} addr_bytes_t;

	// One address word, read whole or as two bytes
	typedef union packed {
		logic [addr_w-1:0] word; // Full 16-bit address
		addr_bytes_t bytes;      // H/L halves for pair stepping
	} addr_word_u;

endpackage

// ==== logic/irq_pkg.sv ====
// Interrupt source count and vector layout used by the interrupt controller

package irq_pkg;

	localparam int irq_n = 8; // Request sources
	localparam int irq_idx_w = 3; // Encoded source index

	// Vectors start at 0x40
	localparam logic [15:0] vec_base = 16'h0040;

	// Vectors are 8 bytes apart
	localparam int vec_stride_log2 = 3;

endpackage

// ==== logic/irq_if.sv ====
// Bundle of interrupt signals shared by the IE decoder, flag slices and priority encoder

`timescale 1ns/1ns

interface irq_if;

	logic ie_load; // IE write strobe
	logic [irq_pkg::irq_n-1:0] ie_wdata; // IE write data
	logic [irq_pkg::irq_n-1:0] irq_trig; // Raw requests
	logic [irq_pkg::irq_n-1:0] ie_q; // IE register contents
	logic [irq_pkg::irq_n-1:0] pend; // Request flags
	logic [irq_pkg::irq_n-1:0] ack; // One-hot acknowledge

	modport decode (
		output ie_load,
		output ie_wdata,
		input ie_q
	);

	// Each slice touches one bit of every vector
	modport slice (
		input ie_load,
		input ie_wdata,
		input irq_trig,
		input ack,
		output ie_q,
		output pend
	);

	modport encoder (
		input pend,
		output ack
	);

endinterface

// ==== logic/addr_incdec.sv ====
// Combinational 16-bit step network for the PC, whole-word or per-byte increment and decrement

`timescale 1ns/1ns

module addr_incdec (
	input addr_pkg::addr_word_u cur,
	input logic inc,
	input logic dec,
	input logic pair, // Step both bytes on their own
	output addr_pkg::addr_word_u nxt
);

	logic step; // Any step requested
	logic [addr_pkg::addr_w-1:0] prop; // Bits that pass a carry or borrow on
	logic [addr_pkg::byte_w:0] c_lo; // Low byte carry chain
	logic [addr_pkg::byte_w:0] c_hi; // High byte carry chain
	logic hi_cin;

	// One byte of ripple, c[i] is the toggle for bit i
	function automatic logic [addr_pkg::byte_w:0] ripple(
		input logic cin,
		input logic [addr_pkg::byte_w-1:0] p
	);
		logic [addr_pkg::byte_w:0] c;
		c[0] = cin;
		for (int i = 0; i < addr_pkg::byte_w; i++) begin
			c[i+1] = c[i] & p[i];
		end
		return c;
	endfunction

	assign step = inc | dec;

	// Increment ripples through ones, decrement through zeros
	assign prop = (cur.word & {addr_pkg::addr_w{inc}}) | (~cur.word & {addr_pkg::addr_w{dec}});

	assign c_lo = ripple(step, prop[addr_pkg::byte_w-1:0]);

	// Pair mode forces the high byte carry like the original chain
	assign hi_cin = pair ? step : c_lo[addr_pkg::byte_w];

	assign c_hi = ripple(hi_cin, prop[addr_pkg::addr_w-1:addr_pkg::byte_w]);

	assign nxt.bytes.lo = cur.bytes.lo ^ c_lo[addr_pkg::byte_w-1:0];
	assign nxt.bytes.hi = cur.bytes.hi ^ c_hi[addr_pkg::byte_w-1:0];

endmodule

// ==== logic/pc_unit.sv ====
// Program counter register with external load, interrupt vector load and inc/dec stepping

`timescale 1ns/1ns

module pc_unit (
	input logic clk,
	input logic arst_n,
	input logic pc_load, // Load from pc_wdata
	input addr_pkg::addr_word_u pc_wdata,
	input logic vec_load, // Interrupt taken this cycle
	input addr_pkg::addr_word_u vec_addr,
	input logic inc,
	input logic dec,
	input logic pair,
	output addr_pkg::addr_word_u pc
);

	addr_pkg::addr_word_u step_nxt; // PC after inc/dec, or PC itself
	addr_pkg::addr_word_u pc_nxt;

	addr_incdec addr_incdec_i (
		.cur(pc),
		.inc(inc),
		.dec(dec),
		.pair(pair),
		.nxt(step_nxt)
	);

	// Vector beats load, load beats step
	always_comb begin
		if (vec_load) begin
			pc_nxt = vec_addr;
		end else if (pc_load) begin
			pc_nxt = pc_wdata;
		end else begin
			pc_nxt = step_nxt;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc.word <= '0;
		end else begin
			pc <= pc_nxt;
		end
	end

	// The sequencer never asks for both directions at once
	inc_dec_excl: assert property (
		@(posedge clk) disable iff (!arst_n) !(inc && dec)
	) else $error("inc and dec high together");

endmodule

// ==== logic/ie_access_decode.sv ====
// Decodes accesses to the interrupt enable register and returns its value on reads

`timescale 1ns/1ns

module ie_access_decode (
	input addr_pkg::addr_word_u addr,
	input logic wr,
	input logic rd,
	input logic [addr_pkg::byte_w-1:0] data_in,
	output logic ie_sel, // Address is the IE register
	output logic [addr_pkg::byte_w-1:0] data_out,
	irq_if.decode bus
);

	// Full compare against 0xFFFF
	assign ie_sel = (addr.word == addr_pkg::ie_addr);

	// IE takes the bus data at the next edge
	assign bus.ie_load = wr & ie_sel;
	assign bus.ie_wdata = data_in;

	// Only the IE register answers here
	assign data_out = (rd && ie_sel) ? bus.ie_q : '0;

endmodule

// ==== logic/irq_flag_slice.sv ====
// One interrupt source: its enable bit and its request flag, instantiated per source

`timescale 1ns/1ns

module irq_flag_slice (
	input logic clk,
	input logic arst_n,
	input logic ie_load, // Shared IE write strobe
	input logic ie_wdata_bit,
	input logic trig, // Raw request for this source
	input logic ack, // Acknowledge for this source
	output logic ie_q,
	output logic pend
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ie_q <= 1'b0;
		end else if (ie_load) begin
			ie_q <= ie_wdata_bit;
		end
	end

	// A fresh request beats a same-cycle acknowledge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend <= 1'b0;
		end else if (trig && ie_q) begin
			pend <= 1'b1;
		end else if (ack) begin
			pend <= 1'b0;
		end
	end

	// The encoder may only acknowledge a raised flag
	ack_needs_pend: assert property (
		@(posedge clk) disable iff (!arst_n) ack |-> pend
	) else $error("ack on a source with no pending flag");

endmodule

// ==== logic/irq_priority.sv ====
// Lowest-index interrupt priority encoder, makes the one-hot acknowledge and the vector address

`timescale 1ns/1ns

module irq_priority (
	input logic ime, // Master interrupt enable
	input logic irq_take, // Sequencer takes an interrupt now
	output logic vec_load, // Acknowledge valid so PC takes the vector
	output addr_pkg::addr_word_u vec_addr,
	output logic irq_pending,
	irq_if.encoder bus
);

	logic [irq_pkg::irq_idx_w-1:0] low_idx; // Lowest pending source
	logic any_pend;

	// Scan down so the lowest set bit is kept
	always_comb begin
		low_idx = '0;
		for (int i = irq_pkg::irq_n - 1; i >= 0; i--) begin
			if (bus.pend[i]) begin
				low_idx = irq_pkg::irq_idx_w'(i);
			end
		end
	end

	assign any_pend = |bus.pend;
	assign irq_pending = any_pend & ime;
	assign vec_load = irq_take & ime & any_pend;

	assign bus.ack = vec_load ? ({{(irq_pkg::irq_n-1){1'b0}}, 1'b1} << low_idx) : '0;

	// 0x40 + 8 * index
	assign vec_addr.word = irq_pkg::vec_base +
		({{(addr_pkg::addr_w-irq_pkg::irq_idx_w){1'b0}}, low_idx} << irq_pkg::vec_stride_log2);

	always_comb begin
		assert ((bus.ack & ~bus.pend) == '0)
			else $error("ack on a source that is not pending");
		assert (!vec_load || (((bus.ack - irq_pkg::irq_n'(1)) & bus.pend) == '0))
			else $error("ack skipped a lower pending source");
	end

endmodule

// ==== logic/cpu_bottom.sv ====
// Top level of the PC address and interrupt datapath, wires the PC unit to the interrupt controller

`timescale 1ns/1ns

module cpu_bottom (
	input logic clk,
	input logic arst_n,
	input logic pc_load, // Load PC from pc_wdata
	input logic [15:0] pc_wdata,
	input logic inc,
	input logic dec,
	input logic pair, // Per-byte stepping
	input logic wr,
	input logic rd,
	input logic [7:0] data_in,
	input logic [7:0] irq_trig,
	input logic ime,
	input logic irq_take,
	output logic [15:0] addr, // Always the current PC
	output logic [7:0] data_out,
	output logic ie_sel,
	output logic [7:0] irq_ack,
	output logic irq_pending
);

	addr_pkg::addr_word_u pc_word; // PC register value
	addr_pkg::addr_word_u pc_wdata_word;
	addr_pkg::addr_word_u vec_word; // Interrupt vector
	logic vec_load;

	irq_if irq_bus ();

	assign pc_wdata_word.word = pc_wdata;
	assign addr = pc_word.word;
	assign irq_bus.irq_trig = irq_trig;
	assign irq_ack = irq_bus.ack;

	pc_unit pc_unit_i (
		.clk(clk),
		.arst_n(arst_n),
		.pc_load(pc_load),
		.pc_wdata(pc_wdata_word),
		.vec_load(vec_load),
		.vec_addr(vec_word),
		.inc(inc),
		.dec(dec),
		.pair(pair),
		.pc(pc_word)
	);

	ie_access_decode ie_access_decode_i (
		.addr(pc_word),
		.wr(wr),
		.rd(rd),
		.data_in(data_in),
		.ie_sel(ie_sel),
		.data_out(data_out),
		.bus(irq_bus.decode)
	);

	// One enable/flag pair per source
	for (genvar i = 0; i < irq_pkg::irq_n; i++) begin : g_slice
		irq_flag_slice irq_flag_slice_i (
			.clk(clk),
			.arst_n(arst_n),
			.ie_load(irq_bus.ie_load),
			.ie_wdata_bit(irq_bus.ie_wdata[i]),
			.trig(irq_bus.irq_trig[i]),
			.ack(irq_bus.ack[i]),
			.ie_q(irq_bus.ie_q[i]),
			.pend(irq_bus.pend[i])
		);
	end

	irq_priority irq_priority_i (
		.ime(ime),
		.irq_take(irq_take),
		.vec_load(vec_load),
		.vec_addr(vec_word),
		.irq_pending(irq_pending),
		.bus(irq_bus.encoder)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset source, instantiated once by the testbench top

`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int period_ns = 4,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Reset released on a falling edge, away from the active edge
	initial begin
		arst_n <= 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		arst_n <= 1'b1;
	end

endmodule

// ==== verif/tb_cpu_bottom.sv ====
// Testbench for cpu_bottom, runs directed and random cycles and checks them against a model

`timescale 1ns/1ns

module tb_cpu_bottom;

	localparam int period_ns = 4;
	localparam int reset_cycles = 10;
	localparam int directed_cycles = 80; // Upper bound over all directed tests
	localparam int rand_cycles = 500;
	localparam int settle_ns = 1; // Inside the low phase
	localparam int watchdog_ns = (reset_cycles + directed_cycles + rand_cycles) * period_ns * 2;

	logic clk;
	logic arst_n;
	logic pc_load;
	logic [15:0] pc_wdata;
	logic inc;
	logic dec;
	logic pair;
	logic wr;
	logic rd;
	logic [7:0] data_in;
	logic [7:0] irq_trig;
	logic ime;
	logic irq_take;
	logic [15:0] addr;
	logic [7:0] data_out;
	logic ie_sel;
	logic [7:0] irq_ack;
	logic irq_pending;

	logic [15:0] m_pc; // Model PC
	logic [7:0] m_ie;
	logic [7:0] m_pend;

	int err_count = 0;
	int test_count = 0;
	int fail_count = 0;
	int test_err_base = 0;
	string test_name;

	tb_clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) tb_clock_gen_i (
		.clk(clk),
		.arst_n(arst_n)
	);

	cpu_bottom cpu_bottom_i (
		.clk(clk),
		.arst_n(arst_n),
		.pc_load(pc_load),
		.pc_wdata(pc_wdata),
		.inc(inc),
		.dec(dec),
		.pair(pair),
		.wr(wr),
		.rd(rd),
		.data_in(data_in),
		.irq_trig(irq_trig),
		.ime(ime),
		.irq_take(irq_take),
		.addr(addr),
		.data_out(data_out),
		.ie_sel(ie_sel),
		.irq_ack(irq_ack),
		.irq_pending(irq_pending)
	);

	// Lowest set bit or zero when none is set
	function automatic int lowest_pending(input logic [7:0] pend);
		int idx;
		bit found;
		idx = 0;
		found = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (pend[i] && !found) begin
				idx = i;
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	function automatic logic [7:0] ack_onehot(input logic [7:0] pend, input logic take,
		input logic ime_v);
		if (take && ime_v && pend != 8'h00) begin
			return 8'(1 << lowest_pending(pend));
		end
		return 8'h00;
	endfunction

	// Vector, then load, then step
	function automatic logic [15:0] next_pc(
		input logic [15:0] cur,
		input logic take_ok,
		input logic [15:0] vec,
		input logic ld,
		input logic [15:0] wdata,
		input logic up,
		input logic down,
		input logic per_byte
	);
		logic [15:0] res;
		if (take_ok) begin
			res = vec;
		end else if (ld) begin
			res = wdata;
		end else if (up && per_byte) begin
			res = {cur[15:8] + 8'd1, cur[7:0] + 8'd1}; // Bytes wrap on their own
		end else if (down && per_byte) begin
			res = {cur[15:8] - 8'd1, cur[7:0] - 8'd1};
		end else if (up) begin
			res = cur + 16'd1;
		end else if (down) begin
			res = cur - 16'd1;
		end else begin
			res = cur;
		end
		return res;
	endfunction

	task automatic compare_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
			err_count++;
		end
	endtask

	// Model steps on the falling edge, then checks what the DUT shows
	always @(negedge clk) begin : model_check
		logic take_ok;
		logic [15:0] vec;
		logic [7:0] new_pend;
		if (arst_n !== 1'b1) begin
			m_pc = 16'h0000;
			m_ie = 8'h00;
			m_pend = 8'h00;
		end else begin
			take_ok = irq_take && ime && (m_pend != 8'h00);
			vec = 16'h0040 + 16'(lowest_pending(m_pend)) * 16'd8;
			new_pend = (m_pend & ~ack_onehot(m_pend, irq_take, ime)) | (irq_trig & m_ie);
			if (wr && m_pc == 16'hFFFF) begin
				m_ie = data_in; // IE write seen at the last edge
			end
			m_pc = next_pc(m_pc, take_ok, vec, pc_load, pc_wdata, inc, dec, pair);
			m_pend = new_pend;
			// Inputs of the last cycle are still held here
			compare_word("addr", addr, m_pc);
			compare_word("irq_ack", 16'(irq_ack), 16'(ack_onehot(m_pend, irq_take, ime)));
			compare_word("irq_pending", 16'(irq_pending), 16'(ime && m_pend != 8'h00));
			compare_word("ie_sel", 16'(ie_sel), 16'(m_pc == 16'hFFFF));
			compare_word("data_out", 16'(data_out),
				(rd && m_pc == 16'hFFFF) ? 16'(m_ie) : 16'h0000);
		end
	end

	// Wait for the next falling edge and drop all one-cycle strobes
	task automatic next_cycle();
		@(negedge clk);
		pc_load <= 1'b0;
		inc <= 1'b0;
		dec <= 1'b0;
		pair <= 1'b0;
		wr <= 1'b0;
		rd <= 1'b0;
		irq_trig <= 8'h00;
		irq_take <= 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_base = err_count;
	endtask

	task automatic end_test();
		int errs;
		next_cycle();
		@(posedge clk); // Last cycle checked by now
		errs = err_count - test_err_base;
		test_count++;
		if (errs == 0) begin
			$display("Test %0d %s: ok", test_count, test_name);
		end else begin
			fail_count++;
			$display("Test %0d %s: %0d errors", test_count, test_name, errs);
		end
	endtask

	task automatic random_run();
		logic [31:0] r;
		for (int n = 0; n < rand_cycles; n++) begin
			next_cycle();
			r = $urandom;
			pc_load <= (r[2:0] == 3'd0);
			inc <= (r[4:3] == 2'd1); // Never both directions
			dec <= (r[4:3] == 2'd2);
			pair <= r[5];
			wr <= r[6];
			rd <= r[7];
			irq_take <= (r[9:8] == 2'd0);
			ime <= (r[12:10] != 3'd0);
			data_in <= r[20:13];
			r = $urandom;
			pc_wdata <= r[16] ? 16'hFFFF : r[15:0]; // Often hits IE
			r = $urandom;
			irq_trig <= r[7:0] & r[15:8] & r[23:16];
		end
	endtask

	initial begin : stimulus
		void'($urandom(79295));
		pc_load <= 1'b0;
		pc_wdata <= 16'h0000;
		inc <= 1'b0;
		dec <= 1'b0;
		pair <= 1'b0;
		wr <= 1'b0;
		rd <= 1'b0;
		data_in <= 8'h00;
		irq_trig <= 8'h00;
		ime <= 1'b0;
		irq_take <= 1'b0;
		wait (arst_n === 1'b1);

		begin_test("load and step, normal mode");
		next_cycle();
		pc_load <= 1'b1;
		pc_wdata <= 16'h00FF;
		next_cycle();
		compare_word("addr", addr, 16'h00FF);
		inc <= 1'b1;
		next_cycle();
		compare_word("addr", addr, 16'h0100);
		pc_load <= 1'b1;
		pc_wdata <= 16'h0000;
		next_cycle();
		dec <= 1'b1;
		next_cycle();
		compare_word("addr", addr, 16'hFFFF);
		end_test();

		begin_test("pair mode");
		next_cycle();
		pc_load <= 1'b1;
		pc_wdata <= 16'h1234;
		next_cycle();
		inc <= 1'b1;
		pair <= 1'b1;
		next_cycle();
		compare_word("addr", addr, 16'h1335);
		pc_load <= 1'b1;
		pc_wdata <= 16'h12FF;
		next_cycle();
		inc <= 1'b1;
		pair <= 1'b1;
		next_cycle();
		compare_word("addr", addr, 16'h1300);
		pc_load <= 1'b1;
		pc_wdata <= 16'h1200;
		next_cycle();
		dec <= 1'b1;
		pair <= 1'b1;
		next_cycle();
		compare_word("addr", addr, 16'h11FF);
		pair <= 1'b1; // Without a step nothing changes
		next_cycle();
		compare_word("addr", addr, 16'h11FF);
		end_test();

		begin_test("IE access");
		next_cycle();
		pc_load <= 1'b1;
		pc_wdata <= 16'hFFFF;
		next_cycle();
		wr <= 1'b1;
		data_in <= 8'h5A;
		next_cycle();
		rd <= 1'b1;
		next_cycle();
		compare_word("data_out", 16'(data_out), 16'h005A);
		compare_word("ie_sel", 16'(ie_sel), 16'h0001);
		pc_load <= 1'b1;
		pc_wdata <= 16'h1234;
		next_cycle();
		wr <= 1'b1; // Not the IE address
		data_in <= 8'hA5;
		next_cycle();
		rd <= 1'b1;
		next_cycle();
		compare_word("data_out", 16'(data_out), 16'h0000);
		compare_word("ie_sel", 16'(ie_sel), 16'h0000);
		pc_load <= 1'b1;
		pc_wdata <= 16'hFFFF;
		next_cycle();
		rd <= 1'b1;
		next_cycle();
		compare_word("data_out", 16'(data_out), 16'h005A);
		end_test();

		begin_test("request flags");
		next_cycle();
		ime <= 1'b1;
		wr <= 1'b1; // PC still at 0xFFFF
		data_in <= 8'h0F;
		next_cycle();
		irq_trig <= 8'hF0; // Disabled sources only
		next_cycle();
		next_cycle();
		compare_word("irq_pending", 16'(irq_pending), 16'h0000);
		ime <= 1'b0;
		irq_trig <= 8'h05;
		next_cycle();
		compare_word("irq_pending", 16'(irq_pending), 16'h0000);
		ime <= 1'b1;
		next_cycle();
		compare_word("irq_pending", 16'(irq_pending), 16'h0001);
		ime <= 1'b0;
		next_cycle();
		compare_word("irq_pending", 16'(irq_pending), 16'h0000);
		end_test();

		begin_test("taking an interrupt");
		next_cycle();
		ime <= 1'b1;
		irq_take <= 1'b1;
		#(settle_ns);
		compare_word("irq_ack", 16'(irq_ack), 16'h0001); // Sources 0 and 2 pending
		next_cycle();
		compare_word("addr", addr, 16'h0040);
		irq_take <= 1'b1;
		#(settle_ns);
		compare_word("irq_ack", 16'(irq_ack), 16'h0004);
		next_cycle();
		compare_word("addr", addr, 16'h0050);
		irq_trig <= 8'h02;
		next_cycle();
		irq_take <= 1'b1;
		pc_load <= 1'b1; // Loses against the take
		pc_wdata <= 16'h1234;
		#(settle_ns);
		compare_word("irq_ack", 16'(irq_ack), 16'h0002);
		next_cycle();
		compare_word("addr", addr, 16'h0048);
		end_test();

		begin_test("random run");
		random_run();
		end_test();

		$display("Tests run %0d, tests failed %0d, errors %0d", test_count, fail_count,
			err_count);
		if (err_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Twice the expected run length
	initial begin : watchdog
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
logic/addr_pkg.sv
logic/irq_pkg.sv
logic/irq_if.sv
logic/addr_incdec.sv
logic/pc_unit.sv
logic/ie_access_decode.sv
logic/irq_flag_slice.sv
logic/irq_priority.sv
logic/cpu_bottom.sv
verif/tb_clock_gen.sv
verif/tb_cpu_bottom.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_cpu_bottom
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
